/* common/axi_macros.svh */
`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

// axi master port widths
`define AXI_ADDR_WIDTH 64
`define AXI_DATA_WIDTH 64
`define AXI_ID_WIDTH   4

// user side line and burst limits
`define LINE_WIDTH     512
`define MAX_BEATS      8

// axi encodings
`define AXI_BURST_INCR 2'b01
`define AXI_RESP_OKAY  2'b00
`define AXI_SIZE_DWORD 2'b11

`endif

/* common/axi_pkg.sv */
`include "axi_macros.svh"

package axi_pkg;

  typedef struct packed {
    logic                        op;    // 1 = write
    logic [`AXI_ADDR_WIDTH-1:0]  addr;
    logic [1:0]                  size;
    logic [7:0]                  blks;  // beats minus one
    logic [`LINE_WIDTH-1:0]      wdata;
  } user_req_t;

  typedef struct packed {
    logic [`LINE_WIDTH-1:0]      rdata;
    logic [1:0]                  resp;  // worst of the burst
  } user_rsp_t;

  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0]  addr;
    logic [`AXI_ID_WIDTH-1:0]    id;
    logic [7:0]                  len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0]  addr;
    logic [`AXI_ID_WIDTH-1:0]    id;
    logic [7:0]                  len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0]   data;
    logic [`AXI_DATA_WIDTH/8-1:0] strb;
    logic                         last;
  } axi_w_t;

  typedef struct packed {
    logic [1:0]                  resp;
    logic [`AXI_ID_WIDTH-1:0]    id;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0]  data;
    logic [1:0]                  resp;
    logic                        last;
    logic [`AXI_ID_WIDTH-1:0]    id;
  } axi_r_t;

endpackage

/* src/mem_arbiter.sv */
`timescale 1ns/1ps
`include "axi_macros.svh"

module mem_arbiter import axi_pkg::*; (
  input  logic                     clock,
  input  logic                     rst_n_i,

  input  logic                     if_valid_i,
  input  user_req_t                if_req_i,
  output logic                     if_ready_o,
  output user_rsp_t                if_rsp_o,

  input  logic                     ls_valid_i,
  input  user_req_t                ls_req_i,
  output logic                     ls_ready_o,
  output user_rsp_t                ls_rsp_o,

  output logic                     bus_valid_o,
  output user_req_t                bus_req_o,
  output logic [`AXI_ID_WIDTH-1:0] bus_id_o,
  input  logic                     bus_ready_i,
  input  user_rsp_t                bus_rsp_i
);

  localparam logic [`AXI_ID_WIDTH-1:0] ID_FETCH = 0;
  localparam logic [`AXI_ID_WIDTH-1:0] ID_LSU   = 1;

  logic      busy_q;
  logic      grant_ls_q;
  logic      sel_ls;
  user_req_t if_req_rd;

  // load/store wins when idle and stays locked while busy
  assign sel_ls = busy_q ? grant_ls_q : ls_valid_i;

  always_comb begin
    if_req_rd    = if_req_i;
    if_req_rd.op = 1'b0;  // fetch only reads
  end

  assign bus_valid_o = sel_ls ? ls_valid_i : if_valid_i;
  assign bus_req_o   = sel_ls ? ls_req_i : if_req_rd;
  assign bus_id_o    = sel_ls ? ID_LSU : ID_FETCH;

  assign if_ready_o = bus_ready_i && !sel_ls;
  assign ls_ready_o = bus_ready_i && sel_ls;
  assign if_rsp_o   = sel_ls ? '0 : bus_rsp_i;
  assign ls_rsp_o   = sel_ls ? bus_rsp_i : '0;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      grant_ls_q <= 1'b0;
    end else if (!busy_q && bus_valid_o) begin
      busy_q     <= 1'b1;
      grant_ls_q <= sel_ls;
    end else if (bus_ready_i) begin
      busy_q <= 1'b0;  // released on the completion pulse
    end
  end

  // granted request stays valid on the same client until the ready pulse
  a_grant_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    (bus_valid_o && !bus_ready_i) |=> (bus_valid_o && (sel_ls == $past(sel_ls))));

endmodule

/* axi_rw/axi_rw.sv */
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_rw import axi_pkg::*; (
  input  logic                     clock,
  input  logic                     rst_n_i,

  input  logic                     user_valid_i,
  input  user_req_t                user_req_i,
  input  logic [`AXI_ID_WIDTH-1:0] user_id_i,
  output logic                     user_ready_o,
  output user_rsp_t                user_rsp_o,

  output logic                     aw_valid_o,
  output axi_aw_t                  aw_o,
  input  logic                     aw_ready_i,
  output logic                     w_valid_o,
  output axi_w_t                   w_o,
  input  logic                     w_ready_i,
  input  logic                     b_valid_i,
  input  axi_b_t                   b_i,
  output logic                     b_ready_o,
  output logic                     ar_valid_o,
  output axi_ar_t                  ar_o,
  input  logic                     ar_ready_i,
  input  logic                     r_valid_i,
  input  axi_r_t                   r_i,
  output logic                     r_ready_o
);

  localparam int DW     = `AXI_DATA_WIDTH;
  localparam int LW     = `LINE_WIDTH;
  localparam int BEAT_W = $clog2(`MAX_BEATS);

  enum logic [2:0] {
    S_IDLE, S_AR, S_R, S_AW, S_W, S_B, S_DONE
  } state_q, state_d;

  user_req_t                req_q;
  logic [`AXI_ID_WIDTH-1:0] id_q;
  logic [BEAT_W-1:0]        beat_q;
  logic [LW-1:0]            line_q;
  logic [1:0]               resp_q;
  logic [DW/8-1:0]          strb_base;
  logic [7:0]               w_cnt_q;  // w beats since the aw handshake

  logic accept;
  logic r_hs;
  logic w_hs;
  logic b_hs;
  logic last_beat;

  assign accept    = (state_q == S_IDLE) && user_valid_i;
  assign r_hs      = (state_q == S_R) && r_valid_i;
  assign w_hs      = (state_q == S_W) && w_ready_i;
  assign b_hs      = (state_q == S_B) && b_valid_i;
  assign last_beat = (beat_q == req_q.blks[BEAT_W-1:0]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (user_valid_i) state_d = user_req_i.op ? S_AW : S_AR;
      S_AR:    if (ar_ready_i) state_d = S_R;
      S_R:     if (r_valid_i && last_beat) state_d = S_DONE;
      S_AW:    if (aw_ready_i) state_d = S_W;
      S_W:     if (w_ready_i && last_beat) state_d = S_B;
      S_B:     if (b_valid_i) state_d = S_DONE;
      S_DONE:  state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == S_IDLE) begin
        beat_q <= '0;
      end else if (r_hs || w_hs) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q  <= user_req_i;
      id_q   <= user_id_i;
      line_q <= user_req_i.op ? user_req_i.wdata : '0;
      resp_q <= `AXI_RESP_OKAY;
    end else if (r_hs) begin
      line_q[beat_q*DW +: DW] <= r_i.data;  // beat k lands at 64k
      if (r_i.resp > resp_q) resp_q <= r_i.resp;
    end else if (w_hs) begin
      line_q <= {{DW{1'b0}}, line_q[LW-1:DW]};  // next beat to the bottom
    end else if (b_hs) begin
      resp_q <= b_i.resp;
    end
  end

  // byte lanes for sub-dword writes
  always_comb begin
    case (req_q.size)
      2'b00:   strb_base = 8'h01;
      2'b01:   strb_base = 8'h03;
      2'b10:   strb_base = 8'h0f;
      default: strb_base = 8'hff;
    endcase
  end

  assign aw_valid_o = (state_q == S_AW);
  assign aw_o = '{
    addr:  req_q.addr,
    id:    id_q,
    len:   req_q.blks,
    size:  {1'b0, req_q.size},
    burst: `AXI_BURST_INCR
  };

  assign w_valid_o = (state_q == S_W);
  assign w_o.data  = line_q[DW-1:0];
  assign w_o.strb  = (req_q.size == `AXI_SIZE_DWORD) ? '1 : (strb_base << req_q.addr[2:0]);
  assign w_o.last  = last_beat;

  assign b_ready_o = (state_q == S_B);

  assign ar_valid_o = (state_q == S_AR);
  assign ar_o = '{
    addr:  req_q.addr,
    id:    id_q,
    len:   req_q.blks,
    size:  {1'b0, req_q.size},
    burst: `AXI_BURST_INCR
  };

  assign r_ready_o = (state_q == S_R);

  assign user_ready_o     = (state_q == S_DONE);
  assign user_rsp_o.rdata = line_q;
  assign user_rsp_o.resp  = resp_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_cnt_q <= '0;
    end else if (aw_valid_o && aw_ready_i) begin
      w_cnt_q <= '0;
    end else if (w_valid_o && w_ready_i) begin
      w_cnt_q <= w_cnt_q + 1'b1;
    end
  end

  // w last only on beat len of the address phase
  a_w_last_on_len: assert property (@(posedge clock) disable iff (!rst_n_i)
    w_valid_o |-> (w_o.last == (w_cnt_q == aw_o.len)));

  a_r_id_match: assert property (@(posedge clock) disable iff (!rst_n_i)
    (r_valid_i && r_ready_o) |-> (r_i.id == id_q));

  a_b_id_match: assert property (@(posedge clock) disable iff (!rst_n_i)
    (b_valid_i && b_ready_o) |-> (b_i.id == id_q));

  // client bursts never exceed one line
  a_blks_range: assert property (@(posedge clock) disable iff (!rst_n_i)
    accept |-> (user_req_i.blks <= `MAX_BEATS - 1));

endmodule

/* src/sim_top.sv */
`timescale 1ns/1ps
`include "axi_macros.svh"

module sim_top import axi_pkg::*; (
  input  logic      clock,
  input  logic      rst_n_i,

  input  logic      if_valid_i,
  input  user_req_t if_req_i,
  output logic      if_ready_o,
  output user_rsp_t if_rsp_o,

  input  logic      ls_valid_i,
  input  user_req_t ls_req_i,
  output logic      ls_ready_o,
  output user_rsp_t ls_rsp_o,

  output logic      aw_valid_o,
  output axi_aw_t   aw_o,
  input  logic      aw_ready_i,
  output logic      w_valid_o,
  output axi_w_t    w_o,
  input  logic      w_ready_i,
  input  logic      b_valid_i,
  input  axi_b_t    b_i,
  output logic      b_ready_o,
  output logic      ar_valid_o,
  output axi_ar_t   ar_o,
  input  logic      ar_ready_i,
  input  logic      r_valid_i,
  input  axi_r_t    r_i,
  output logic      r_ready_o
);

  // arbiter to bridge
  logic                     bus_valid;
  user_req_t                bus_req;
  logic [`AXI_ID_WIDTH-1:0] bus_id;
  logic                     bus_ready;
  user_rsp_t                bus_rsp;

  mem_arbiter u_mem_arbiter (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .if_valid_i  (if_valid_i),
    .if_req_i    (if_req_i),
    .if_ready_o  (if_ready_o),
    .if_rsp_o    (if_rsp_o),
    .ls_valid_i  (ls_valid_i),
    .ls_req_i    (ls_req_i),
    .ls_ready_o  (ls_ready_o),
    .ls_rsp_o    (ls_rsp_o),
    .bus_valid_o (bus_valid),
    .bus_req_o   (bus_req),
    .bus_id_o    (bus_id),
    .bus_ready_i (bus_ready),
    .bus_rsp_i   (bus_rsp)
  );

  axi_rw u_axi_rw (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .user_valid_i (bus_valid),
    .user_req_i   (bus_req),
    .user_id_i    (bus_id),
    .user_ready_o (bus_ready),
    .user_rsp_o   (bus_rsp),
    .aw_valid_o   (aw_valid_o),
    .aw_o         (aw_o),
    .aw_ready_i   (aw_ready_i),
    .w_valid_o    (w_valid_o),
    .w_o          (w_o),
    .w_ready_i    (w_ready_i),
    .b_valid_i    (b_valid_i),
    .b_i          (b_i),
    .b_ready_o    (b_ready_o),
    .ar_valid_o   (ar_valid_o),
    .ar_o         (ar_o),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_i          (r_i),
    .r_ready_o    (r_ready_o)
  );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock_o,
  output logic rst_n_o
);

  initial begin
    clock_o = 1'b0;
    forever #50 clock_o = ~clock_o;  // 100 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clock_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* tests/tb_sim_top.sv */
`timescale 1ns/1ps

module tb_sim_top import axi_pkg::*; ();

  localparam int          MEM_WORDS = 4096;
  localparam int          TIMEOUT   = 2000;
  localparam logic [63:0] ERR_BASE  = 64'h8000;
  localparam logic [1:0]  SLVERR    = 2'b10;

  logic      clock;
  logic      rst_n;
  logic      if_valid;
  user_req_t if_req;
  logic      if_ready;
  user_rsp_t if_rsp;
  logic      ls_valid;
  user_req_t ls_req;
  logic      ls_ready;
  user_rsp_t ls_rsp;

  logic    aw_valid, w_valid, b_ready, ar_valid, r_ready;
  axi_aw_t aw_pay;
  axi_w_t  w_pay;
  axi_ar_t ar_pay;
  logic    aw_ready, w_ready, b_valid, ar_ready, r_valid;
  axi_b_t  b_pay;
  axi_r_t  r_pay;

  logic [63:0] mem [MEM_WORDS];     // slave model contents
  logic [63:0] shadow [MEM_WORDS];  // reference copy
  logic [31:0] lcg_state = 32'h91f7;

  user_rsp_t exp_q[$];
  user_rsp_t got_q[$];
  bit        wr_q[$];
  int        errors = 0;
  int        checks = 0;
  int        ls_ready_cnt = 0;

  tb_clock_gen u_clock_gen (.clock_o(clock), .rst_n_o(rst_n));

  sim_top i_dut (
    .clock(clock), .rst_n_i(rst_n),
    .if_valid_i(if_valid), .if_req_i(if_req), .if_ready_o(if_ready), .if_rsp_o(if_rsp),
    .ls_valid_i(ls_valid), .ls_req_i(ls_req), .ls_ready_o(ls_ready), .ls_rsp_o(ls_rsp),
    .aw_valid_o(aw_valid), .aw_o(aw_pay), .aw_ready_i(aw_ready),
    .w_valid_o(w_valid), .w_o(w_pay), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_i(b_pay), .b_ready_o(b_ready),
    .ar_valid_o(ar_valid), .ar_o(ar_pay), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_i(r_pay), .r_ready_o(r_ready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_delay();
    logic [31:0] v;
    v = lcg_next();
    return int'(v[18:16]);
  endfunction

  function automatic logic [63:0] fill_word(int i);
    return {32'(i) * 32'h9e3779b1, ~32'(i)};
  endfunction

  // expected response from the bus rules on the shadow memory
  function automatic user_rsp_t ref_access(user_req_t rq);
    user_rsp_t   rs;
    logic [63:0] a;
    logic [7:0]  strb;
    logic [63:0] wd;
    int          nbytes;
    rs = '0;
    nbytes = 1 << rq.size;
    strb = 8'((16'h1 << nbytes) - 1) << rq.addr[2:0];
    for (int k = 0; k <= int'(rq.blks); k++) begin
      a = {rq.addr[63:3], 3'b000} + 64'(k * 8);
      wd = rq.wdata[k*64 +: 64];
      if (a >= ERR_BASE) begin
        rs.resp = SLVERR;
      end else if (rq.op) begin
        for (int j = 0; j < 8; j++)
          if (strb[j]) shadow[a[14:3]][j*8 +: 8] = wd[j*8 +: 8];
      end else begin
        rs.rdata[k*64 +: 64] = shadow[a[14:3]];
      end
    end
    return rs;
  endfunction

  task automatic fail_timeout(string what);
    $display("timeout while waiting for %s", what);
    $display(">>> FAIL");
    $finish;
  endtask

  // address phase against the pending client request, load/store has priority
  task automatic check_addr_phase(string ch, logic [3:0] id, logic [2:0] size,
                                  logic [1:0] burst);
    user_req_t  rq;
    logic [3:0] exp_id;
    rq = ls_valid ? ls_req : if_req;
    exp_id = ls_valid ? 4'd1 : 4'd0;
    if (id !== exp_id) begin
      $display("MISMATCH %s_id: got %h expected %h", ch, id, exp_id);
      errors++;
    end
    if (size !== {1'b0, rq.size}) begin
      $display("MISMATCH %s_size: got %h expected %h", ch, size, {1'b0, rq.size});
      errors++;
    end
    if (burst !== 2'b01) begin
      $display("MISMATCH %s_burst: got %h expected %h", ch, burst, 2'b01);
      errors++;
    end
  endtask

  task automatic stall();
    int d;
    d = rand_delay();
    repeat (d) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic serve_read();
    axi_ar_t     ar;
    logic [63:0] a;
    ar = ar_pay;
    check_addr_phase("ar", ar.id, ar.size, ar.burst);
    stall();
    ar_ready = 1'b1;
    @(posedge clock);
    #1 ar_ready = 1'b0;
    for (int k = 0; k <= int'(ar.len); k++) begin
      stall();
      a = {ar.addr[63:3], 3'b000} + 64'(k * 8);
      r_pay.data = (a < ERR_BASE) ? mem[a[14:3]] : '0;
      r_pay.resp = (a < ERR_BASE) ? 2'b00 : SLVERR;
      r_pay.last = (k == int'(ar.len));
      r_pay.id   = ar.id;
      r_valid = 1'b1;
      if (r_ready !== 1'b1) begin
        $display("MISMATCH r_ready: got %h expected %h", r_ready, 1'b1);
        errors++;
      end
      @(posedge clock);
      #1 r_valid = 1'b0;
    end
  endtask

  task automatic serve_write();
    axi_aw_t     aw;
    axi_w_t      wb;
    logic [63:0] a;
    logic [1:0]  resp;
    aw = aw_pay;
    resp = 2'b00;
    check_addr_phase("aw", aw.id, aw.size, aw.burst);
    stall();
    aw_ready = 1'b1;
    @(posedge clock);
    #1 aw_ready = 1'b0;
    for (int k = 0; k <= int'(aw.len); k++) begin
      stall();
      w_ready = 1'b1;
      wb = w_pay;
      if (wb.last !== (k == int'(aw.len))) begin
        $display("MISMATCH w_last beat %0d: got %h expected %h", k, wb.last, k == int'(aw.len));
        errors++;
      end
      a = {aw.addr[63:3], 3'b000} + 64'(k * 8);
      if (a >= ERR_BASE) begin
        resp = SLVERR;
      end else begin
        for (int j = 0; j < 8; j++)
          if (wb.strb[j]) mem[a[14:3]][j*8 +: 8] = wb.data[j*8 +: 8];
      end
      @(posedge clock);
      #1 w_ready = 1'b0;
    end
    stall();
    b_pay = '{resp: resp, id: aw.id};
    b_valid = 1'b1;
    if (b_ready !== 1'b1) begin
      $display("MISMATCH b_ready: got %h expected %h", b_ready, 1'b1);
      errors++;
    end
    @(posedge clock);
    #1 b_valid = 1'b0;
  endtask

  initial begin : axi_slave
    forever begin
      @(posedge clock);
      #1;
      if (ar_valid) serve_read();
      else if (aw_valid) serve_write();
    end
  end

  always @(negedge clock) if (ls_ready) ls_ready_cnt++;

  // compares each finished access with its reference response
  always @(negedge clock) begin : compare
    user_rsp_t e;
    user_rsp_t g;
    bit        w;
    if (got_q.size() > 0) begin
      e = exp_q.pop_front();
      g = got_q.pop_front();
      w = wr_q.pop_front();
      checks++;
      if (g.resp !== e.resp) begin
        $display("MISMATCH resp: got %h expected %h", g.resp, e.resp);
        errors++;
      end
      if (!w && g.rdata !== e.rdata) begin
        $display("MISMATCH rdata: got %h expected %h", g.rdata, e.rdata);
        errors++;
      end
    end
  end

  task automatic run_access(input bit use_ls, input user_req_t rq, output time t_done);
    user_rsp_t exp;
    user_rsp_t got;
    int        n;
    exp = ref_access(rq);
    @(posedge clock);
    #1;
    if (use_ls) begin
      ls_req = rq;
      ls_valid = 1'b1;
    end else begin
      if_req = rq;
      if_valid = 1'b1;
    end
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clock);
      if (use_ls ? ls_ready : if_ready) break;
    end
    if (n == TIMEOUT) begin
      fail_timeout("the user ready pulse");
    end else begin
      got = use_ls ? ls_rsp : if_rsp;
      t_done = $time;
      exp_q.push_back(exp);
      got_q.push_back(got);
      wr_q.push_back(rq.op);
      @(posedge clock);
      #1;
      if (use_ls) ls_valid = 1'b0;
      else if_valid = 1'b0;
    end
  endtask

  function automatic user_req_t make_req(bit op, logic [63:0] addr, logic [1:0] size,
                                         logic [7:0] blks, logic [511:0] wdata);
    user_req_t rq;
    rq.op = op;
    rq.addr = addr;
    rq.size = size;
    rq.blks = blks;
    rq.wdata = wdata;
    return rq;
  endfunction

  initial begin : main
    user_req_t    rq_a;
    user_req_t    rq_b;
    time          t_ls;
    time          t_if;
    int           n;
    int           err0;
    int           ls0;
    int           passed;
    int           failed;
    logic [31:0]  v;
    logic [511:0] wd;
    logic [1:0]   sz;
    logic [7:0]   bl;
    logic [63:0]  ad;
    bit           use_ls;

    passed = 0;
    failed = 0;
    if_valid = 1'b0;
    ls_valid = 1'b0;
    if_req = '0;
    ls_req = '0;
    aw_ready = 1'b0;
    w_ready = 1'b0;
    b_valid = 1'b0;
    b_pay = '0;
    ar_ready = 1'b0;
    r_valid = 1'b0;
    r_pay = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
      shadow[i] = fill_word(i);
    end

    for (n = 0; n < TIMEOUT && !rst_n; n++) @(posedge clock);
    if (n == TIMEOUT) fail_timeout("reset release");
    @(negedge clock);
    if (aw_valid || w_valid || ar_valid || b_ready || r_ready || if_ready || ls_ready) begin
      $display("a valid or ready output is high after reset");
      errors++;
    end

    for (int t = 1; t <= 6; t++) begin
      err0 = errors;
      case (t)
        1: run_access(1'b1, make_req(1'b0, 64'h40, 2'd3, 8'd0, '0), t_ls);
        2: begin
          ls0 = ls_ready_cnt;
          run_access(1'b0, make_req(1'b0, 64'h200, 2'd3, 8'd7, '0), t_if);
          if (ls_ready_cnt != ls0) begin
            $display("load/store client saw ready during a fetch");
            errors++;
          end
        end
        3: begin
          run_access(1'b1, make_req(1'b1, 64'h10b, 2'd0, 8'd0, {8{64'h5a5a_a5a5_c3c3_3c3c}}),
                     t_ls);
          run_access(1'b1, make_req(1'b0, 64'h108, 2'd3, 8'd0, '0), t_ls);
        end
        4: begin
          rq_a = make_req(1'b0, 64'h400, 2'd3, 8'd3, '0);
          rq_b = make_req(1'b0, 64'h800, 2'd3, 8'd7, '0);
          fork
            run_access(1'b1, rq_a, t_ls);
            run_access(1'b0, rq_b, t_if);
          join
          if (t_ls >= t_if) begin
            $display("fetch was answered before load/store");
            errors++;
          end
        end
        5: begin
          for (int i = 0; i < 40; i++) begin
            v = lcg_next();
            use_ls = v[0];
            if (v[5]) begin
              sz = 2'd3;
              bl = {5'd0, v[4:2]};
            end else begin
              sz = v[7:6];
              bl = 8'd0;
            end
            ad = 64'((lcg_next() % (MEM_WORDS - 8)) * 8);
            if (sz != 2'd3) ad[2:0] = v[10:8] & ~3'((1 << sz) - 1);  // aligned to size
            for (int j = 0; j < 16; j++) wd[j*32 +: 32] = lcg_next();
            run_access(use_ls, make_req(use_ls & v[1], ad, sz, bl, wd), t_ls);
          end
        end
        default: begin
          run_access(1'b1, make_req(1'b0, 64'h8000, 2'd3, 8'd1, '0), t_ls);
          run_access(1'b1, make_req(1'b1, 64'h9000, 2'd3, 8'd0, {8{64'h1234}}), t_ls);
        end
      endcase
      for (n = 0; n < TIMEOUT && got_q.size() > 0; n++) @(posedge clock);
      if (n == TIMEOUT) fail_timeout("the compare queue to drain");
      @(posedge clock);
      if (errors == err0) begin
        passed++;
        $display("test %0d: ok", t);
      end else begin
        failed++;
        $display("test %0d: %0d errors", t, errors - err0);
      end
    end

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             passed, failed, checks, errors);
    if (errors == 0 && failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/axi_pkg.sv
src/mem_arbiter.sv
axi_rw/axi_rw.sv
src/sim_top.sv
tests/tb_clock_gen.sv
tests/tb_sim_top.sv
